/* l2_cache.f */
+incdir+source
source/l2_cache_pkg.sv
source/l2_ctrl_pkg.sv
source/l2_way_arrays.sv
source/l2_evict_buffer.sv
source/l2_pmem_arbiter.sv
source/l2_cache_control.sv
source/l2_cache.sv
dv/pmem_model.sv
dv/l2_cache_tb.sv

/* Makefile */
SIM      = verilator
TOP      = l2_cache_tb
FILELIST = l2_cache.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/l2_cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache_tb;

    import l2_cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int WORDS = `L2_LINE_BITS / 32;

    logic     clk;
    logic     rst;
    logic     mem_read;
    logic     mem_write;
    l2_addr_t mem_address;
    l2_line_t mem_wdata;
    l2_line_t mem_rdata;
    logic     mem_resp;
    logic     pmem_read;
    logic     pmem_write;
    l2_addr_t pmem_address;
    l2_line_t pmem_wdata;
    l2_line_t pmem_rdata;
    logic     pmem_resp;
    int       model_faults;

    // golden memory holding the lines the cpu has written
    l2_line_t golden [l2_addr_t];

    integer   seed;
    string    test_name;
    int       check_count;
    int       error_count;
    int       errors_before;
    int       wb_count;
    int       wb_errors;
    int       last_latency;
    bit       timed_out;

    l2_cache u_l2_cache
    (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    pmem_model #(.SEED(32'hcfd9)) u_pmem
    (
        .clk          (clk),
        .rst          (rst),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .fault_count  (model_faults)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic l2_addr_t line_of(l2_addr_t a);
        return {a[`L2_ADDR_BITS-1:`L2_OFFSET_BITS], {`L2_OFFSET_BITS{1'b0}}};
    endfunction

    function automatic l2_addr_t line_address(l2_tag_t t, l2_index_t i);
        return {t, i, {`L2_OFFSET_BITS{1'b0}}};
    endfunction

    // power-up content of memory
    function automatic l2_line_t pattern_line(l2_addr_t line_addr);
        l2_line_t l;
        for (int i = 0; i < WORDS; i++)
        begin
            l[i*32 +: 32] = line_addr + l2_addr_t'(i);
        end
        return l;
    endfunction

    // reference is the last cpu write to the line or else the pattern
    function automatic l2_line_t expected_line(l2_addr_t a);
        l2_addr_t la;
        la = line_of(a);
        if (golden.exists(la))
        begin
            return golden[la];
        end
        return pattern_line(la);
    endfunction

    function automatic l2_line_t random_line();
        l2_line_t l;
        for (int i = 0; i < WORDS; i++)
        begin
            l[i*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    // 12 lines made of 4 tags in each of sets 3, 5 and 6 at any byte offset
    function automatic l2_addr_t mix_address(int unsigned r);
        l2_index_t idx;
        l2_tag_t   tg;
        case (r % 3)
            0:       idx = 3'd3;
            1:       idx = 3'd5;
            default: idx = 3'd6;
        endcase
        tg = 24'h000a00 + l2_tag_t'((r / 3) % 4);
        return {tg, idx, r[28:24]};
    endfunction

    task automatic compare_line(input string what, input l2_addr_t a,
                                input l2_line_t exp_line, input l2_line_t act_line);
        check_count++;
        assert (act_line == exp_line)
        else
        begin
            error_count++;
            $display("Mismatch %s %s at %h expected %h actual %h",
                     test_name, what, a, exp_line, act_line);
        end
    endtask

    task automatic check_quiet_ports();
        check_count++;
        assert (!mem_resp && !pmem_read && !pmem_write)
        else
        begin
            error_count++;
            $display("Mismatch %s resp/read/write expected 000 actual %b%b%b",
                     test_name, mem_resp, pmem_read, pmem_write);
        end
    endtask

    task automatic check_latency(input int expected);
        check_count++;
        assert (last_latency == expected)
        else
        begin
            error_count++;
            $display("Mismatch %s hit latency expected %0d actual %0d",
                     test_name, expected, last_latency);
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = error_count;
    endtask

    task automatic end_test();
        $display("test %-12s done, %0d errors", test_name, error_count - errors_before);
    endtask

    // one cpu request held until mem_resp and dropped in the cycle after
    task automatic cpu_access(input logic is_write, input l2_addr_t a, input l2_line_t data);
        int cycles;
        // a hung request ends all further stimulus
        if (!timed_out)
        begin
            @(posedge clk);
            #1;
            mem_address = a;
            mem_wdata   = data;
            mem_read    = !is_write;
            mem_write   = is_write;
            cycles      = 0;
            do
            begin
                @(negedge clk);
                cycles++;
            end
            while (!mem_resp && (cycles < TIMEOUT_CYCLES));
            if (!mem_resp)
            begin
                timed_out = 1'b1;
                error_count++;
                $display("timeout: no mem_resp within %0d cycles in %s at %h",
                         TIMEOUT_CYCLES, test_name, a);
            end
            else
            begin
                last_latency = cycles;
                @(posedge clk);
                #1;
                mem_read  = 1'b0;
                mem_write = 1'b0;
                // response must have been a single cycle
                @(negedge clk);
                check_count++;
                assert (!mem_resp)
                else
                begin
                    error_count++;
                    $display("Mismatch %s mem_resp after drop expected 0 actual %b",
                             test_name, mem_resp);
                end
            end
        end
    endtask

    // read data and write-backs are checked before golden takes cpu writes
    always @(negedge clk)
    begin : compare
        int errors_seen;
        if (!rst)
        begin
            if (mem_resp && mem_read)
            begin
                compare_line("read", mem_address, expected_line(mem_address), mem_rdata);
            end
            if (pmem_resp && pmem_write)
            begin
                errors_seen = error_count;
                wb_count++;
                compare_line("write-back", pmem_address, expected_line(pmem_address),
                             pmem_wdata);
                wb_errors += error_count - errors_seen;
            end
            if (mem_resp && mem_write)
            begin
                golden[line_of(mem_address)] = mem_wdata;
            end
        end
    end

    initial
    begin
        l2_addr_t    a;
        int unsigned r;

        seed        = 32'hcfd9;
        check_count = 0;
        error_count = 0;
        wb_count    = 0;
        wb_errors   = 0;
        timed_out   = 1'b0;
        rst         = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;

        // strobes low in reset and just after
        begin_test("reset");
        @(posedge clk);
        @(negedge clk);
        check_quiet_ports();
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_quiet_ports();
        end_test();

        // one untouched line per set so every read misses
        begin_test("cold_read");
        for (int i = 0; i < 8; i++)
        begin
            cpu_access(1'b0, line_address(24'h000020 + l2_tag_t'(i), l2_index_t'(i)), '0);
        end
        end_test();

        // write miss allocates and the reads then hit
        begin_test("write_read");
        a = 32'h0000_5548;
        cpu_access(1'b1, a, random_line());
        cpu_access(1'b0, a, '0);
        cpu_access(1'b0, a, '0);
        check_latency(2);
        end_test();

        // five dirty lines into four ways of set 3
        begin_test("conflict_set");
        for (int i = 0; i < 5; i++)
        begin
            cpu_access(1'b1, line_address(24'h000100 + l2_tag_t'(i), 3'd3), random_line());
        end
        for (int i = 0; i < 5; i++)
        begin
            cpu_access(1'b0, line_address(24'h000100 + l2_tag_t'(i), 3'd3), '0);
        end
        end_test();

        begin_test("random_mix");
        for (int n = 0; n < 200; n++)
        begin
            r = $random(seed);
            cpu_access(r[16], mix_address(r), random_line());
        end
        end_test();

        // write-backs were checked all along by the compare block
        begin_test("writeback");
        check_count++;
        assert (wb_count > 0)
        else
        begin
            error_count++;
            $display("%s saw no write-back reach memory", test_name);
        end
        $display("test %-12s done, %0d errors over %0d memory writes",
                 test_name, wb_errors + error_count - errors_before, wb_count);
        $display("checks %0d, errors %0d, memory model faults %0d",
                 check_count, error_count, model_faults);
        if ((error_count == 0) && (model_faults == 0))
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : l2_cache_tb

`default_nettype wire

/* dv/pmem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module pmem_model
#(
    parameter int SEED = 32'hcfd9
)
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pmem_read,
    input  wire                         pmem_write,
    input  wire l2_cache_pkg::l2_addr_t pmem_address,
    input  wire l2_cache_pkg::l2_line_t pmem_wdata,
    output l2_cache_pkg::l2_line_t      pmem_rdata,
    output logic                        pmem_resp,
    output int                          fault_count
);

    import l2_cache_pkg::*;

    // written-back lines, everything else still follows the pattern
    l2_line_t mem [l2_addr_t];
    integer   seed;

    // word i of a line holds the line address plus i
    function automatic l2_line_t initial_line(l2_addr_t line_addr);
        l2_line_t l;
        for (int i = 0; i < `L2_LINE_BITS / 32; i++)
        begin
            l[i*32 +: 32] = line_addr + l2_addr_t'(i);
        end
        return l;
    endfunction

    function automatic l2_line_t read_line(l2_addr_t a);
        if (mem.exists(a))
        begin
            return mem[a];
        end
        return initial_line(a);
    endfunction

    // one request at a time, answer after 1 to 4 cycles
    initial
    begin
        l2_addr_t req_address;
        l2_line_t req_data;
        logic     req_write;
        int       latency;

        seed        = SEED;
        pmem_resp   = 1'b0;
        pmem_rdata  = '0;
        fault_count = 0;
        forever
        begin
            @(posedge clk);
            #1;
            if (!rst && (pmem_read || pmem_write))
            begin
                req_address = pmem_address;
                req_data    = pmem_wdata;
                req_write   = pmem_write;
                assert (!(pmem_read && pmem_write))
                else
                begin
                    fault_count++;
                    $display("memory model: read and write raised together at %h", req_address);
                end
                assert (req_address[`L2_OFFSET_BITS-1:0] == '0)
                else
                begin
                    fault_count++;
                    $display("memory model: address %h is not line aligned", req_address);
                end
                latency = 1 + ($unsigned($random(seed)) % 4);
                repeat (latency)
                begin
                    @(posedge clk);
                    #1;
                    // request, address and write data stay put until the answer
                    assert ((pmem_write == req_write) && (pmem_read == !req_write) &&
                            (pmem_address == req_address) &&
                            (!req_write || (pmem_wdata == req_data)))
                    else
                    begin
                        fault_count++;
                        $display("memory model: request at %h changed before its answer",
                                 req_address);
                    end
                end
                if (req_write)
                begin
                    mem[req_address] = req_data;
                end
                else
                begin
                    pmem_rdata = read_line(req_address);
                end
                pmem_resp = 1'b1;
                // arbiter drops the request at this edge
                @(posedge clk);
                #1;
                pmem_resp = 1'b0;
            end
        end
    end

endmodule : pmem_model

`default_nettype wire

/* source/l2_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache
(
    input  wire                         clk,
    input  wire                         rst,

    // cpu side
    input  wire                         mem_read,
    input  wire                         mem_write,
    input  wire l2_cache_pkg::l2_addr_t mem_address,
    input  wire l2_cache_pkg::l2_line_t mem_wdata,
    output l2_cache_pkg::l2_line_t      mem_rdata,
    output logic                        mem_resp,

    // physical memory side
    output logic                        pmem_read,
    output logic                        pmem_write,
    output l2_cache_pkg::l2_addr_t      pmem_address,
    output l2_cache_pkg::l2_line_t      pmem_wdata,
    input  wire l2_cache_pkg::l2_line_t pmem_rdata,
    input  wire                         pmem_resp
);

    import l2_cache_pkg::*;

    // address fields
    l2_tag_t   tag;
    l2_index_t index;

    // arrays
    logic      hit;
    logic      victim_dirty;
    l2_tag_t   victim_tag;
    l2_line_t  victim_line;
    l2_line_t  array_rdata;
    logic      touch;
    logic      write_hit;
    logic      install;
    logic      invalidate;

    // eviction buffer
    logic      ewb_hit;
    logic      ewb_empty;
    logic      ewb_draining;
    l2_line_t  ewb_rdata;
    logic      ewb_load;
    logic      ewb_write;
    logic      drain_req;
    logic      drain_done;
    l2_addr_t  drain_address;
    l2_line_t  drain_data;

    // fill path
    logic      fill_req;
    logic      fill_done;
    l2_line_t  fill_line;

    assign tag   = mem_address[`L2_ADDR_BITS-1 -: `L2_TAG_BITS];
    assign index = mem_address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];

    l2_cache_control u_control
    (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .array_rdata  (array_rdata),
        .touch        (touch),
        .write_hit    (write_hit),
        .install      (install),
        .invalidate   (invalidate),
        .ewb_hit      (ewb_hit),
        .ewb_empty    (ewb_empty),
        .ewb_draining (ewb_draining),
        .ewb_rdata    (ewb_rdata),
        .ewb_load     (ewb_load),
        .ewb_write    (ewb_write),
        .fill_req     (fill_req),
        .fill_done    (fill_done)
    );

    l2_way_arrays u_arrays
    (
        .clk          (clk),
        .rst          (rst),
        .index        (index),
        .tag          (tag),
        .wdata        (mem_wdata),
        .fill_line    (fill_line),
        .touch        (touch),
        .write_hit    (write_hit),
        .install      (install),
        .invalidate   (invalidate),
        .hit          (hit),
        .array_rdata  (array_rdata),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line)
    );

    l2_evict_buffer u_ewb
    (
        .clk           (clk),
        .rst           (rst),
        .index         (index),
        .tag           (tag),
        .victim_tag    (victim_tag),
        .victim_line   (victim_line),
        .wdata         (mem_wdata),
        .ewb_load      (ewb_load),
        .ewb_write     (ewb_write),
        .drain_done    (drain_done),
        .ewb_hit       (ewb_hit),
        .ewb_empty     (ewb_empty),
        .ewb_draining  (ewb_draining),
        .ewb_rdata     (ewb_rdata),
        .drain_req     (drain_req),
        .drain_address (drain_address),
        .drain_data    (drain_data)
    );

    l2_pmem_arbiter u_arbiter
    (
        .clk           (clk),
        .rst           (rst),
        .fill_req      (fill_req),
        .mem_address   (mem_address),
        .drain_req     (drain_req),
        .drain_address (drain_address),
        .drain_data    (drain_data),
        .pmem_rdata    (pmem_rdata),
        .pmem_resp     (pmem_resp),
        .fill_done     (fill_done),
        .fill_line     (fill_line),
        .drain_done    (drain_done),
        .pmem_read     (pmem_read),
        .pmem_write    (pmem_write),
        .pmem_address  (pmem_address),
        .pmem_wdata    (pmem_wdata)
    );

endmodule : l2_cache

`default_nettype wire

/* source/l2_cache_control.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control
(
    input  wire                         clk,
    input  wire                         rst,

    // cpu request, held until mem_resp
    input  wire                         mem_read,
    input  wire                         mem_write,
    output logic                        mem_resp,
    output l2_cache_pkg::l2_line_t      mem_rdata,

    // way arrays
    input  wire                         hit,
    input  wire                         victim_dirty,
    input  wire l2_cache_pkg::l2_line_t array_rdata,
    output logic                        touch,
    output logic                        write_hit,
    output logic                        install,
    output logic                        invalidate,

    // eviction buffer
    input  wire                         ewb_hit,
    input  wire                         ewb_empty,
    input  wire                         ewb_draining,
    input  wire l2_cache_pkg::l2_line_t ewb_rdata,
    output logic                        ewb_load,
    output logic                        ewb_write,

    // line fill through the arbiter
    output logic                        fill_req,
    input  wire                         fill_done
);

    import l2_ctrl_pkg::*;

    l2_state_e state;
    l2_state_e state_next;

    // a buffered line is never valid in the ways as well
    assign mem_rdata = ewb_hit ? ewb_rdata : array_rdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        mem_resp   = 1'b0;
        touch      = 1'b0;
        write_hit  = 1'b0;
        install    = 1'b0;
        invalidate = 1'b0;
        ewb_load   = 1'b0;
        ewb_write  = 1'b0;
        fill_req   = 1'b0;

        case (state)
            IDLE:
            begin
                if (mem_read || mem_write)
                begin
                    state_next = LOOKUP;
                end
            end

            LOOKUP:
            begin
                if (hit)
                begin
                    // answer this cycle, pseudo-LRU and dirty bit follow at the edge
                    mem_resp   = 1'b1;
                    touch      = 1'b1;
                    write_hit  = mem_write;
                    state_next = IDLE;
                end
                else if (ewb_hit)
                begin
                    // line is on its way to memory so a write must wait
                    if (!(mem_write && ewb_draining))
                    begin
                        mem_resp   = 1'b1;
                        ewb_write  = mem_write;
                        state_next = IDLE;
                    end
                end
                else if (victim_dirty)
                begin
                    state_next = EVICT;
                end
                else
                begin
                    // clean or invalid victim is simply overwritten
                    state_next = FILL;
                end
            end

            EVICT:
            begin
                // only one buffered line at a time
                if (ewb_empty)
                begin
                    ewb_load   = 1'b1;
                    invalidate = 1'b1;
                    state_next = FILL;
                end
            end

            FILL:
            begin
                fill_req = 1'b1;
                if (fill_done)
                begin
                    state_next = INSTALL;
                end
            end

            INSTALL:
            begin
                // next lookup hits and finishes the request
                install    = 1'b1;
                state_next = LOOKUP;
            end

            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

endmodule : l2_cache_control

`default_nettype wire

/* source/l2_pmem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_pmem_arbiter
(
    input  wire                         clk,
    input  wire                         rst,

    // fill peer
    input  wire                         fill_req,
    input  wire l2_cache_pkg::l2_addr_t mem_address,
    output logic                        fill_done,
    output l2_cache_pkg::l2_line_t      fill_line,

    // drain peer
    input  wire                         drain_req,
    input  wire l2_cache_pkg::l2_addr_t drain_address,
    input  wire l2_cache_pkg::l2_line_t drain_data,
    output logic                        drain_done,

    // memory port
    output logic                        pmem_read,
    output logic                        pmem_write,
    output l2_cache_pkg::l2_addr_t      pmem_address,
    output l2_cache_pkg::l2_line_t      pmem_wdata,
    input  wire l2_cache_pkg::l2_line_t pmem_rdata,
    input  wire                         pmem_resp
);

    import l2_ctrl_pkg::*;

    pmem_grant_e grant;

    // fill wins a tie, grant held through pmem_resp
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            grant <= GNT_NONE;
        end
        else if (grant == GNT_NONE)
        begin
            if (fill_req)
            begin
                grant <= GNT_FILL;
            end
            else if (drain_req)
            begin
                grant <= GNT_DRAIN;
            end
        end
        else if (pmem_resp)
        begin
            grant <= GNT_NONE;
        end
    end

    // pmem_rdata is gone after the response cycle
    always_ff @(posedge clk)
    begin
        if (fill_done)
        begin
            fill_line <= pmem_rdata;
        end
    end

    assign pmem_read  = (grant == GNT_FILL);
    assign pmem_write = (grant == GNT_DRAIN);
    assign fill_done  = pmem_resp && pmem_read;
    assign drain_done = pmem_resp && pmem_write;

    // fill reads the whole line
    assign pmem_address = pmem_write ? drain_address :
        {mem_address[`L2_ADDR_BITS-1:`L2_OFFSET_BITS], {`L2_OFFSET_BITS{1'b0}}};
    assign pmem_wdata   = drain_data;

endmodule : l2_pmem_arbiter

`default_nettype wire

/* source/l2_evict_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_evict_buffer
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire l2_cache_pkg::l2_index_t index,
    input  wire l2_cache_pkg::l2_tag_t   tag,
    input  wire l2_cache_pkg::l2_tag_t   victim_tag,
    input  wire l2_cache_pkg::l2_line_t  victim_line,
    input  wire l2_cache_pkg::l2_line_t  wdata,
    input  wire                          ewb_load,
    input  wire                          ewb_write,
    input  wire                          drain_done,
    output logic                         ewb_hit,
    output logic                         ewb_empty,
    output logic                         ewb_draining,
    output l2_cache_pkg::l2_line_t       ewb_rdata,
    output logic                         drain_req,
    output l2_cache_pkg::l2_addr_t       drain_address,
    output l2_cache_pkg::l2_line_t       drain_data
);

    import l2_cache_pkg::*;

    logic      full;
    l2_tag_t   buf_tag;
    l2_index_t buf_index;
    l2_line_t  buf_line;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            full         <= 1'b0;
            ewb_draining <= 1'b0;
        end
        else
        begin
            // load only happens while empty
            if (ewb_load)
            begin
                full <= 1'b1;
            end
            else if (drain_done)
            begin
                full <= 1'b0;
            end
            // set one cycle after the request first shows up
            if (drain_done)
            begin
                ewb_draining <= 1'b0;
            end
            else if (drain_req)
            begin
                ewb_draining <= 1'b1;
            end
        end
    end

    // victim address is its tag plus the set being missed on
    always_ff @(posedge clk)
    begin
        if (ewb_load)
        begin
            buf_tag   <= victim_tag;
            buf_index <= index;
            buf_line  <= victim_line;
        end
        else if (ewb_write)
        begin
            // cpu write to the held line
            buf_line <= wdata;
        end
    end

    assign ewb_hit       = full && (buf_tag == tag) && (buf_index == index);
    assign ewb_empty     = ~full;
    assign ewb_rdata     = buf_line;
    assign drain_req     = full;
    assign drain_data    = buf_line;
    assign drain_address = {buf_tag, buf_index, {`L2_OFFSET_BITS{1'b0}}};

endmodule : l2_evict_buffer

`default_nettype wire

/* source/l2_way_arrays.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_way_arrays
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire l2_cache_pkg::l2_index_t index,
    input  wire l2_cache_pkg::l2_tag_t   tag,
    input  wire l2_cache_pkg::l2_line_t  wdata,
    input  wire l2_cache_pkg::l2_line_t  fill_line,
    input  wire                          touch,
    input  wire                          write_hit,
    input  wire                          install,
    input  wire                          invalidate,
    output logic                         hit,
    output l2_cache_pkg::l2_line_t       array_rdata,
    output logic                         victim_dirty,
    output l2_cache_pkg::l2_tag_t        victim_tag,
    output l2_cache_pkg::l2_line_t       victim_line
);

    import l2_cache_pkg::*;

    localparam int SETS = 1 << `L2_INDEX_BITS;

    // per way storage
    l2_tag_t  tag_mem  [`L2_WAYS][SETS];
    l2_line_t data_mem [`L2_WAYS][SETS];

    // per set status, one bit per way
    logic [`L2_WAYS-1:0] valid [SETS];
    logic [`L2_WAYS-1:0] dirty [SETS];
    l2_plru_t            plru  [SETS];

    logic [`L2_WAYS-1:0] set_valid;
    l2_plru_t            set_plru;
    l2_plru_t            plru_next;
    l2_way_t             hit_way;
    l2_way_t             plru_way;
    l2_way_t             victim_way;

    assign set_valid = valid[index];
    assign set_plru  = plru[index];

    // tag compare over the set
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (set_valid[w] && (tag_mem[w][index] == tag))
            begin
                hit     = 1'b1;
                hit_way = l2_way_t'(w);
            end
        end
    end

    // tree walk
    // bit 2 low points at ways 2/3, high at ways 0/1
    always_comb
    begin
        if (!set_plru[2])
        begin
            plru_way = set_plru[0] ? 2'd2 : 2'd3;
        end
        else
        begin
            plru_way = set_plru[1] ? 2'd0 : 2'd1;
        end
    end

    // invalid way first, scanning down leaves the lowest one
    always_comb
    begin
        victim_way = plru_way;
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (!set_valid[w])
            begin
                victim_way = l2_way_t'(w);
            end
        end
    end

    // point the tree away from the way just used
    always_comb
    begin
        plru_next = set_plru;
        if (!hit_way[1])
        begin
            plru_next[2] = 1'b0;
            plru_next[1] = hit_way[0];
        end
        else
        begin
            plru_next[2] = 1'b1;
            plru_next[0] = hit_way[0];
        end
    end

    assign array_rdata  = data_mem[hit_way][index];
    assign victim_tag   = tag_mem[victim_way][index];
    assign victim_line  = data_mem[victim_way][index];
    assign victim_dirty = set_valid[victim_way] & dirty[index][victim_way];

    // status bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                valid[s] <= '0;
                dirty[s] <= '0;
                plru[s]  <= '0;
            end
        end
        else
        begin
            if (touch)
            begin
                plru[index] <= plru_next;
            end
            // fresh fill is clean
            if (install)
            begin
                valid[index][victim_way] <= 1'b1;
                dirty[index][victim_way] <= 1'b0;
            end
            // victim has moved to the buffer
            if (invalidate)
            begin
                valid[index][victim_way] <= 1'b0;
            end
            if (write_hit)
            begin
                dirty[index][hit_way] <= 1'b1;
            end
        end
    end

    // tags and lines
    always_ff @(posedge clk)
    begin
        if (install)
        begin
            tag_mem[victim_way][index]  <= tag;
            data_mem[victim_way][index] <= fill_line;
        end
        if (write_hit)
        begin
            data_mem[hit_way][index] <= wdata;
        end
    end

endmodule : l2_way_arrays

`default_nettype wire

/* source/l2_ctrl_pkg.sv */
`default_nettype none

package l2_ctrl_pkg;

    // request FSM
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        FILL,
        INSTALL
    } l2_state_e;

    // owner of the memory port
    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_FILL,
        GNT_DRAIN
    } pmem_grant_e;

endpackage : l2_ctrl_pkg

`default_nettype wire

/* source/l2_cache_pkg.sv */
`default_nettype none

`include "l2_cache_macros.svh"

package l2_cache_pkg;

    // full byte address
    typedef logic [`L2_ADDR_BITS-1:0] l2_addr_t;

    // whole line, the unit of every transfer
    typedef logic [`L2_LINE_BITS-1:0] l2_line_t;

    // address fields
    typedef logic [`L2_TAG_BITS-1:0] l2_tag_t;
    typedef logic [`L2_INDEX_BITS-1:0] l2_index_t;

    // way number within a set
    typedef logic [$clog2(`L2_WAYS)-1:0] l2_way_t;

    // tree bits, one fewer than the ways
    // bit 2 picks the half, bit 1 covers ways 0/1, bit 0 covers ways 2/3
    typedef logic [`L2_WAYS-2:0] l2_plru_t;

endpackage : l2_cache_pkg

`default_nettype wire

/* source/l2_cache_macros.svh */
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

// byte address on both ports
`define L2_ADDR_BITS 32

// one line is 32 bytes
`define L2_LINE_BITS 256
`define L2_OFFSET_BITS 5

// 8 sets of 4 ways
`define L2_INDEX_BITS 3
`define L2_WAYS 4

// what is left above index and offset
`define L2_TAG_BITS (`L2_ADDR_BITS - `L2_INDEX_BITS - `L2_OFFSET_BITS)

`endif
